// File: list.f
+incdir+verilog
verilog/gpioPkg.sv
verilog/gpioCtrlIf.sv
verilog/pinSync.sv
verilog/gpioRegs.sv
verilog/extIntDetect.sv
verilog/altPinMux.sv
verilog/gpio.sv
testbench/tbClkGen.sv
testbench/gpioTb.sv

// File: testbench/gpioTb.sv
// GPIO testbench with a pin model, a reference model and a compare process
`include "gpio_consts.svh"

module gpioTb;
	timeunit 1ns;
	timeprecision 100ps;
	import gpioPkg::*;

	// ------------------------------
	// Run limit and constants
	// ------------------------------
	localparam int        TEST_CYCLES = 800;                // Six tests, rounded up
	localparam int        CYCLE_LIMIT = TEST_CYCLES * 5 / 2;
	localparam gpioWord_t CFG_MASK    = 16'h5F00;           // Bits 14 and 12..8

	logic      clk;
	logic      arstN;
	memAddr_t  memAddr;
	gpioWord_t memDataIn;
	logic      memWrEn;
	gpioWord_t memDataOut;
	logic      intEXH;
	logic      intEXL;
	logic      pwmTmr2;
	logic      pwmTmr3;
	logic      uartTX;
	logic      i2cSCL;
	logic      i2cSDAIn;
	logic      i2cSDADir;
	logic      uartRX;
	logic      i2cSDAOut;
	wire gpioWord_t gpioPins;

	// Reference copies of the DUT registers
	gpioWord_t mCfg;
	gpioWord_t mDir;
	gpioWord_t mOut;
	gpioWord_t tbDrv;      // Levels offered by the pin model
	gpioWord_t tbEn;       // Pins the pin model wants to drive
	gpioWord_t dutEnRef;   // Pins the DUT should be driving

	logic checkEn;         // Compare process armed
	int   seed = 66508;
	int   errCnt = 0;
	int   checkCnt = 0;
	int   testNum = 0;
	int   testErr0 = 0;
	int   testChk0 = 0;
	int   cycleCnt = 0;
	int   dutCntH = 0;     // Pulses seen on o_intEXH
	int   dutCntL = 0;

	tbClkGen tbClkGen_inst (
		.o_clk   (clk),
		.o_arstN (arstN)
	);

	gpio gpio_inst (
		.i_clk        (clk),
		.i_arstN      (arstN),
		.i_memAddr    (memAddr),
		.i_memDataIn  (memDataIn),
		.i_memWrEn    (memWrEn),
		.o_memDataOut (memDataOut),
		.o_intEXH     (intEXH),
		.o_intEXL     (intEXL),
		.i_pwmTmr2    (pwmTmr2),
		.i_pwmTmr3    (pwmTmr3),
		.i_uartTX     (uartTX),
		.i_i2cSCL     (i2cSCL),
		.i_i2cSDAIn   (i2cSDAIn),
		.i_i2cSDADir  (i2cSDADir),
		.o_uartRX     (uartRX),
		.o_i2cSDAOut  (i2cSDAOut),
		.io_gpioPins  (gpioPins)
	);

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic gpioWord_t refDrvEn(input gpioWord_t dir, input gpioWord_t cfg,
		input logic sdaDir);
		gpioWord_t en;
		en = dir;
		if (cfg[`PIN_SDA]) begin
			en[`PIN_SDA] = sdaDir;   // I2C block turns SDA around
		end
		return en;
	endfunction

	// Expected read word, settled pin levels and read lines
	function automatic void refExpect(
		input  memAddr_t  addr,
		output gpioWord_t rdWord,
		output gpioWord_t pinLvl,
		output logic      uartRx,
		output logic      sdaRx
	);
		gpioWord_t en;
		gpioWord_t val;
		en  = refDrvEn(mDir, mCfg, i2cSDADir);
		val = mOut;
		val[`PIN_TMR3] = mCfg[`PIN_TMR3] ? pwmTmr3 : mOut[`PIN_TMR3];
		val[`PIN_TMR2] = mCfg[`PIN_TMR2] ? pwmTmr2 : mOut[`PIN_TMR2];
		val[`PIN_SDA]  = mCfg[`PIN_SDA] ? i2cSDAIn : mOut[`PIN_SDA];
		val[`PIN_SCL]  = mCfg[`PIN_SDA] ? i2cSCL : mOut[`PIN_SCL];   // I2C enable covers SCL
		val[`PIN_UTX]  = mCfg[`PIN_URX] ? uartTX : mOut[`PIN_UTX];   // UART enable covers TX
		for (int p = 0; p < `GPIO_WIDTH; p++) begin
			// DUT drive first, then pin model, else pulldown
			pinLvl[p] = en[p] ? val[p] : (tbEn[p] & tbDrv[p]);
		end
		case (addr)
			`ADDR_CFG: rdWord = mCfg;
			`ADDR_PIN: rdWord = pinLvl;
			`ADDR_DIR: rdWord = mDir;
			default:   rdWord = mOut;
		endcase
		uartRx = mCfg[`PIN_URX] ? pinLvl[`PIN_URX] : 1'b1;  // Idle high when off
		sdaRx  = mCfg[`PIN_SDA] ? pinLvl[`PIN_SDA] : 1'b1;
	endfunction

	// Edges on pins 9 and 8 that land on the configured level
	function automatic logic [1:0] edgeHits(input logic [1:0] prev, input logic [1:0] now,
		input logic [1:0] pol);
		logic [1:0] hits;
		for (int i = 0; i < 2; i++) begin
			hits[i] = (now[i] != prev[i]) && (now[i] == pol[i]);
		end
		return hits;
	endfunction

	// ------------------------------
	// Pin model
	// ------------------------------
	assign dutEnRef = refDrvEn(mDir, mCfg, i2cSDADir);

	for (genvar p = 0; p < `GPIO_WIDTH; p++) begin : g_pinModel
		pulldown (gpioPins[p]);
		// Only drive where the DUT should be listening
		assign gpioPins[p] = (tbEn[p] && !dutEnRef[p]) ? tbDrv[p] : 1'bz;
	end

	// ------------------------------
	// Compare process
	// ------------------------------
	task automatic compareValue(input string name, input gpioWord_t exp, input gpioWord_t act);
		checkCnt++;
		assert (act === exp) else begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			errCnt++;
		end
	endtask

	always @(negedge clk) begin : compareProc
		gpioWord_t expRd;
		gpioWord_t expPins;
		logic      expRx;
		logic      expSda;
		if (checkEn) begin
			refExpect(memAddr, expRd, expPins, expRx, expSda);
			compareValue("o_memDataOut", expRd, memDataOut);
			compareValue("io_gpioPins", expPins, gpioPins);
			compareValue("o_uartRX", expRx, uartRX);
			compareValue("o_i2cSDAOut", expSda, i2cSDAOut);
		end
	end

	// Mid-cycle sample sees each one-cycle pulse once
	always @(negedge clk) begin
		if (intEXH === 1'b1) begin
			dutCntH++;
		end
		if (intEXL === 1'b1) begin
			dutCntL++;
		end
	end

	// ------------------------------
	// Stimulus tasks
	// ------------------------------
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic busWrite(input memAddr_t addr, input gpioWord_t data);
		@(posedge clk);
		memAddr   <= addr;
		memDataIn <= data;
		memWrEn   <= 1'b1;
		@(posedge clk);                  // DUT captures here
		memWrEn <= 1'b0;
		case (addr)
			`ADDR_CFG: mCfg <= data & CFG_MASK;
			`ADDR_DIR: mDir <= data;
			`ADDR_OUT: mOut <= data;
			default:   ;                 // Pin view is read only
		endcase
	endtask

	// Settle the synchronizer, then step through all four views
	task automatic readAllViews();
		waitCycles(`SYNC_STAGES + 1);
		for (int a = 0; a < 4; a++) begin
			@(posedge clk);
			memAddr <= memAddr_t'(a);
			checkEn <= 1'b1;
		end
		@(posedge clk);
		checkEn <= 1'b0;
	endtask

	task automatic driveAltInputs();
		int r;
		r = $random(seed);
		@(posedge clk);
		pwmTmr2   <= r[0];
		pwmTmr3   <= r[1];
		uartTX    <= r[2];
		i2cSCL    <= r[3];
		i2cSDAIn  <= r[4];
		i2cSDADir <= r[5];
	endtask

	task automatic finishTest(input string name);
		testNum++;
		$display("Test %0d %s: %0d checks, %0d errors", testNum, name,
			checkCnt - testChk0, errCnt - testErr0);
		testChk0 = checkCnt;
		testErr0 = errCnt;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin : mainSeq
		int         r;
		logic [1:0] lvl;
		logic [1:0] hits;
		int         expCntH;
		int         expCntL;
		memAddr   = '0;
		memDataIn = '0;
		memWrEn   = 1'b0;
		pwmTmr2   = 1'b0;
		pwmTmr3   = 1'b0;
		uartTX    = 1'b0;
		i2cSCL    = 1'b0;
		i2cSDAIn  = 1'b0;
		i2cSDADir = 1'b0;
		mCfg      = '0;
		mDir      = '0;
		mOut      = '0;
		tbDrv     = '0;
		tbEn      = '0;
		checkEn   = 1'b0;
		wait (arstN === 1'b1);
		@(posedge clk);

		// Reset state, pins pulled low
		@(negedge clk);
		compareValue("o_intEXH", '0, intEXH);
		compareValue("o_intEXL", '0, intEXL);
		readAllViews();
		@(posedge clk);
		tbDrv <= '1;                     // Any DUT driver would show as X
		tbEn  <= '1;
		readAllViews();
		@(posedge clk);
		tbEn <= '0;
		finishTest("reset state");

		// Random writes, address 01 included
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			busWrite(memAddr_t'(r[17:16]), r[15:0]);
			readAllViews();
		end
		finishTest("register readback");

		// Plain GPIO inputs
		busWrite(`ADDR_CFG, '0);
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			busWrite(`ADDR_DIR, r[15:0]);
			busWrite(`ADDR_OUT, r[31:16]);
			r = $random(seed);
			@(posedge clk);
			tbDrv <= r[15:0];
			tbEn  <= '1;
			readAllViews();
		end
		finishTest("pin input");

		// Plain GPIO outputs, undriven pins pulled low
		@(posedge clk);
		tbEn <= '0;
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			busWrite(`ADDR_DIR, r[15:0]);
			busWrite(`ADDR_OUT, r[31:16]);
			readAllViews();
		end
		finishTest("output drive");

		// Alternate functions
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			busWrite(`ADDR_CFG, r[15:0]);
			busWrite(`ADDR_DIR, r[31:16]);
			r = $random(seed);
			busWrite(`ADDR_OUT, r[15:0]);
			driveAltInputs();
			@(posedge clk);
			tbDrv <= r[31:16];
			tbEn  <= '1;
			readAllViews();
		end
		finishTest("alternate functions");

		// Interrupts, all four polarity pairs
		busWrite(`ADDR_DIR, '0);
		for (int pol = 0; pol < 4; pol++) begin
			busWrite(`ADDR_CFG, gpioWord_t'(pol) << `PIN_INTL);
			@(posedge clk);
			tbEn <= '1;
			waitCycles(5);               // Drain setup pulses
			lvl     = tbDrv[`PIN_INTH:`PIN_INTL];
			dutCntH = 0;
			dutCntL = 0;
			expCntH = 0;
			expCntL = 0;
			for (int s = 0; s < 8; s++) begin
				r    = $random(seed);
				hits = edgeHits(lvl, r[1:0], pol[1:0]);
				expCntH += hits[1];
				expCntL += hits[0];
				lvl = r[1:0];
				@(posedge clk);
				tbDrv[`PIN_INTH:`PIN_INTL] <= lvl;
				waitCycles(4);           // Held five cycles
			end
			waitCycles(5);
			compareValue("o_intEXH pulses", expCntH, dutCntH);
			compareValue("o_intEXL pulses", expCntL, dutCntL);
		end
		finishTest("interrupts");

		$display("Tests %0d, checks %0d, errors %0d", testNum, checkCnt, errCnt);
		if (errCnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// ------------------------------
	// Watchdog
	// ------------------------------
	initial begin : watchdog
		while (cycleCnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCnt++;
		end
		$display("Timeout after %0d cycles, the test sequence did not finish", cycleCnt);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: testbench/tbClkGen.sv
// Testbench clock and reset source, 10 ns clock with a two-cycle reset
module tbClkGen (
	output logic o_clk,
	output logic o_arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 5;  // 10 ns period

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Reset held for two rising edges
	initial begin
		o_arstN = 1'b0;
		repeat (2) @(posedge o_clk);
		o_arstN <= 1'b1;
	end

endmodule

// File: verilog/altPinMux.sv
// Alternate function mux driving the GPIO tristates and the UART and I2C read lines
`include "gpio_consts.svh"

module altPinMux (
	input  gpioPkg::gpioWord_t      i_pinSync,
	gpioCtrlIf.pins                 ctrl,
	input  logic                    i_pwmTmr2,
	input  logic                    i_pwmTmr3,
	input  logic                    i_uartTX,
	input  logic                    i_i2cSCL,
	input  logic                    i_i2cSDAIn,   // Data the I2C block drives out
	input  logic                    i_i2cSDADir,  // 1 while I2C drives SDA
	output logic                    o_uartRX,
	output logic                    o_i2cSDAOut,  // Data back to the I2C block
	inout  wire gpioPkg::gpioWord_t io_gpioPins
);
	import gpioPkg::*;

	gpioWord_t drvVal;    // Value per pin
	gpioWord_t drvEn;     // Drive enable per pin

	// ------------------------------
	// Function select
	// ------------------------------
	always_comb begin
		// Plain GPIO unless a function takes over
		drvVal = ctrl.out;
		drvEn  = ctrl.dir;
		if (ctrl.cfgTmr3) begin
			drvVal[`PIN_TMR3] = i_pwmTmr3;
		end
		if (ctrl.cfgTmr2) begin
			drvVal[`PIN_TMR2] = i_pwmTmr2;
		end
		if (ctrl.cfgI2c) begin
			drvVal[`PIN_SDA] = i_i2cSDAIn;
			drvVal[`PIN_SCL] = i_i2cSCL;
			// SDA turns around under I2C control
			drvEn[`PIN_SDA]  = i_i2cSDADir;
		end
		if (ctrl.cfgUart) begin
			drvVal[`PIN_UTX] = i_uartTX;  // RX pin keeps GPIO drive
		end
	end

	// ------------------------------
	// Tristate drivers
	// ------------------------------
	for (genvar p = 0; p < $bits(gpioWord_t); p++) begin : g_tri
		assign io_gpioPins[p] = drvEn[p] ? drvVal[p] : 1'bz;
	end

	// ------------------------------
	// Internal read lines
	// ------------------------------
	// Idle high when the function is off
	assign o_uartRX    = i_pinSync[`PIN_URX] | ~ctrl.cfgUart;
	assign o_i2cSDAOut = i_pinSync[`PIN_SDA] | ~ctrl.cfgI2c;

endmodule

// File: verilog/extIntDetect.sv
// External interrupt detector producing one-cycle pulses on pin 9 and pin 8 edges
`include "gpio_consts.svh"

module extIntDetect (
	input  logic               i_clk,
	input  logic               i_arstN,
	input  gpioPkg::gpioWord_t i_pinSync,
	gpioCtrlIf.intr            ctrl,
	output logic               o_intEXH,
	output logic               o_intEXL
);

	// ------------------------------
	// Edge detect
	// ------------------------------
	// Index 1 is the high pin, index 0 the low pin
	logic [1:0] curLvl;
	logic [1:0] prevQ;    // Level seen last cycle
	logic [1:0] polarity; // 1 means rising
	logic [1:0] edgeHit;
	logic [1:0] intQ;

	assign curLvl   = {i_pinSync[`PIN_INTH], i_pinSync[`PIN_INTL]};
	assign polarity = {ctrl.cfgIntH, ctrl.cfgIntL};

	// A change whose new level matches polarity
	assign edgeHit = (curLvl ^ prevQ) & ~(curLvl ^ polarity);

	// ------------------------------
	// Pulse registers
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			prevQ <= '0;
			intQ  <= '0;
		end else begin
			prevQ <= curLvl;
			intQ  <= edgeHit;   // High for one cycle per edge
		end
	end

	assign o_intEXH = intQ[1];
	assign o_intEXL = intQ[0];

endmodule

// File: verilog/gpio.sv
// GPIO port top, a memory-mapped 16-pin port with alternate functions and pin interrupts
`include "gpio_consts.svh"

module gpio (
	// Clock and reset
	input  logic                    i_clk,
	input  logic                    i_arstN,

	// Processor bus
	input  gpioPkg::memAddr_t       i_memAddr,
	input  gpioPkg::gpioWord_t      i_memDataIn,
	input  logic                    i_memWrEn,
	output gpioPkg::gpioWord_t      o_memDataOut,

	// External interrupts
	output logic                    o_intEXH,
	output logic                    o_intEXL,

	// Alternate function sources and sinks
	input  logic                    i_pwmTmr2,
	input  logic                    i_pwmTmr3,
	input  logic                    i_uartTX,
	input  logic                    i_i2cSCL,
	input  logic                    i_i2cSDAIn,
	input  logic                    i_i2cSDADir,
	output logic                    o_uartRX,
	output logic                    o_i2cSDAOut,

	// Package pins
	inout  wire gpioPkg::gpioWord_t io_gpioPins
);
	import gpioPkg::*;

	// ------------------------------
	// Internal wiring
	// ------------------------------
	gpioWord_t pinSyncW;  // Synchronized pins, three readers

	gpioCtrlIf ctrlIf ();

	// ------------------------------
	// Input synchronizer
	// ------------------------------
	pinSync #(
		.WIDTH   (`GPIO_WIDTH)
	) pinSync_inst (
		.i_clk   (i_clk),
		.i_arstN (i_arstN),
		.i_async (io_gpioPins),
		.o_sync  (pinSyncW)
	);

	// ------------------------------
	// Registers and read mux
	// ------------------------------
	gpioRegs gpioRegs_inst (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_memAddr    (i_memAddr),
		.i_memDataIn  (i_memDataIn),
		.i_memWrEn    (i_memWrEn),
		.i_pinSync    (pinSyncW),
		.o_memDataOut (o_memDataOut),
		.ctrl         (ctrlIf.regs)
	);

	// ------------------------------
	// Pin interrupts
	// ------------------------------
	extIntDetect extIntDetect_inst (
		.i_clk     (i_clk),
		.i_arstN   (i_arstN),
		.i_pinSync (pinSyncW),
		.ctrl      (ctrlIf.intr),
		.o_intEXH  (o_intEXH),
		.o_intEXL  (o_intEXL)
	);

	// ------------------------------
	// Pin drivers
	// ------------------------------
	altPinMux altPinMux_inst (
		.i_pinSync   (pinSyncW),
		.ctrl        (ctrlIf.pins),
		.i_pwmTmr2   (i_pwmTmr2),
		.i_pwmTmr3   (i_pwmTmr3),
		.i_uartTX    (i_uartTX),
		.i_i2cSCL    (i_i2cSCL),
		.i_i2cSDAIn  (i_i2cSDAIn),
		.i_i2cSDADir (i_i2cSDADir),
		.o_uartRX    (o_uartRX),
		.o_i2cSDAOut (o_i2cSDAOut),
		.io_gpioPins (io_gpioPins)
	);

endmodule

// File: verilog/gpioCtrlIf.sv
// GPIO control interface carrying register state from the register block to pin logic
interface gpioCtrlIf;
	import gpioPkg::*;

	// Alternate function enables
	logic      cfgUart;   // Pins 15/14 to UART
	logic      cfgI2c;    // Pins 13/12 to I2C
	logic      cfgTmr2;   // Pin 11 to TMR2 PWM
	logic      cfgTmr3;   // Pin 10 to TMR3 PWM

	// Interrupt polarity, 1 is rising
	logic      cfgIntH;
	logic      cfgIntL;

	// Per-pin drive state
	gpioWord_t dir;       // 1 drives the pin
	gpioWord_t out;       // Value when driven

	// Register side owns everything
	modport regs (
		output cfgUart, cfgI2c, cfgTmr2, cfgTmr3, cfgIntH, cfgIntL, dir, out
	);

	// Pin mux only needs function enables and drive state
	modport pins (
		input cfgUart, cfgI2c, cfgTmr2, cfgTmr3, dir, out
	);

	// Edge detector only needs polarity
	modport intr (
		input cfgIntH, cfgIntL
	);

endinterface

// File: verilog/gpioPkg.sv
// GPIO package with the vector types shared across the port
`include "gpio_consts.svh"

package gpioPkg;

	// ------------------------------
	// Data words
	// ------------------------------
	// One bit per pin, also the bus data width
	typedef logic [`GPIO_WIDTH-1:0] gpioWord_t;

	// ------------------------------
	// Bus addressing
	// ------------------------------
	// Selects one of the four register views
	typedef logic [1:0] memAddr_t;

endpackage

// File: verilog/gpioRegs.sv
// GPIO register block holding config, direction and output state with the bus read mux
`include "gpio_consts.svh"

module gpioRegs (
	input  logic               i_clk,
	input  logic               i_arstN,
	input  gpioPkg::memAddr_t  i_memAddr,
	input  gpioPkg::gpioWord_t i_memDataIn,
	input  logic               i_memWrEn,
	input  gpioPkg::gpioWord_t i_pinSync,
	output gpioPkg::gpioWord_t o_memDataOut,
	gpioCtrlIf.regs            ctrl
);
	import gpioPkg::*;

	// ------------------------------
	// Address decode
	// ------------------------------
	logic      cfgWrEn;
	logic      dirWrEn;
	logic      outWrEn;

	logic [5:0] cfgQ;     // {UART, I2C, TMR2, TMR3, IntH, IntL}
	gpioWord_t  dirQ;
	gpioWord_t  outQ;
	gpioWord_t  cfgRdWord;  // Sparse view of cfgQ

	// No enable for ADDR_PIN, writes there drop
	assign cfgWrEn = i_memWrEn && (i_memAddr == `ADDR_CFG);
	assign dirWrEn = i_memWrEn && (i_memAddr == `ADDR_DIR);
	assign outWrEn = i_memWrEn && (i_memAddr == `ADDR_OUT);

	// ------------------------------
	// Registers
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			cfgQ <= '0;
			dirQ <= '0;   // All pins released
			outQ <= '0;
		end else begin
			if (cfgWrEn) begin
				// Pack the six meaningful bits
				cfgQ <= {i_memDataIn[`PIN_URX], i_memDataIn[`PIN_SDA],
					i_memDataIn[`PIN_TMR2], i_memDataIn[`PIN_TMR3],
					i_memDataIn[`PIN_INTH], i_memDataIn[`PIN_INTL]};
			end
			if (dirWrEn) begin
				dirQ <= i_memDataIn;
			end
			if (outWrEn) begin
				outQ <= i_memDataIn;
			end
		end
	end

	// Fan register state out to pin logic
	assign ctrl.cfgUart = cfgQ[5];
	assign ctrl.cfgI2c  = cfgQ[4];
	assign ctrl.cfgTmr2 = cfgQ[3];
	assign ctrl.cfgTmr3 = cfgQ[2];
	assign ctrl.cfgIntH = cfgQ[1];
	assign ctrl.cfgIntL = cfgQ[0];
	assign ctrl.dir     = dirQ;
	assign ctrl.out     = outQ;

	// ------------------------------
	// Read path
	// ------------------------------
	// Config bits return at their write positions, rest zero
	always_comb begin
		cfgRdWord            = '0;
		cfgRdWord[`PIN_URX]  = cfgQ[5];
		cfgRdWord[`PIN_SDA]  = cfgQ[4];
		cfgRdWord[`PIN_TMR2] = cfgQ[3];
		cfgRdWord[`PIN_TMR3] = cfgQ[2];
		cfgRdWord[`PIN_INTH] = cfgQ[1];
		cfgRdWord[`PIN_INTL] = cfgQ[0];
	end

	always_comb begin
		o_memDataOut = '0;
		case (i_memAddr)
			`ADDR_CFG: o_memDataOut = cfgRdWord;
			`ADDR_PIN: o_memDataOut = i_pinSync;   // Synced pin levels
			`ADDR_DIR: o_memDataOut = dirQ;
			`ADDR_OUT: o_memDataOut = outQ;
			default:   o_memDataOut = '0;
		endcase
	end

endmodule

// File: verilog/gpio_consts.svh
// GPIO constants for port width, synchronizer depth, register map and alternate pins
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// ------------------------------
// Port geometry
// ------------------------------
`define GPIO_WIDTH  16         // Pins on the port
`define SYNC_STAGES 2          // Flops per input synchronizer

// ------------------------------
// Register word addresses
// ------------------------------
`define ADDR_CFG    2'b00      // Alternate function and interrupt config
`define ADDR_PIN    2'b01      // Synchronized pin levels, read only
`define ADDR_DIR    2'b10      // Direction, 1 drives the pin
`define ADDR_OUT    2'b11      // Output value

// ------------------------------
// Alternate function pins
// ------------------------------
// Config bits sit at the same positions as these pin indices
`define PIN_INTL    8          // Low external interrupt
`define PIN_INTH    9          // High external interrupt
`define PIN_TMR3    10         // Timer 3 PWM out
`define PIN_TMR2    11         // Timer 2 PWM out
`define PIN_SDA     12         // I2C data, bidirectional
`define PIN_SCL     13         // I2C clock
`define PIN_URX     14         // UART receive, input only
`define PIN_UTX     15         // UART transmit

`endif

// File: verilog/pinSync.sv
// Pin synchronizer, a multi-flop chain per bit for asynchronous pin inputs
`include "gpio_consts.svh"

module pinSync #(
	parameter int WIDTH = `GPIO_WIDTH
) (
	input  logic             i_clk,
	input  logic             i_arstN,
	input  logic [WIDTH-1:0] i_async,   // Raw pin levels
	output logic [WIDTH-1:0] o_sync     // Safe to use in i_clk domain
);

	// Stage 0 may go metastable, later stages settle it
	logic [WIDTH-1:0] syncQ [`SYNC_STAGES];

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int s = 0; s < `SYNC_STAGES; s++) begin
				syncQ[s] <= '0;
			end
		end else begin
			syncQ[0] <= i_async;
			// Shift down the chain
			for (int s = 1; s < `SYNC_STAGES; s++) begin
				syncQ[s] <= syncQ[s-1];
			end
		end
	end

	assign o_sync = syncQ[`SYNC_STAGES-1];  // Last stage only

endmodule
